//--- lsu_pkg.sv
`default_nettype none

package lsu_pkg;

	localparam int NUM_LANES = 4;
	localparam int LANE_W    = 2;
	localparam int TAG_W     = 5;
	localparam int ADDR_W    = 32;
	localparam int DATA_W    = 32;
	localparam int STRB_W    = DATA_W / 8;

	typedef enum logic [3:0] {
		OP_PASS = 4'd0,
		OP_LB   = 4'd1,
		OP_LH   = 4'd2,
		OP_LW   = 4'd3,
		OP_LBU  = 4'd4,
		OP_LHU  = 4'd5,
		OP_SB   = 4'd6,
		OP_SH   = 4'd7,
		OP_SW   = 4'd8
	} lsu_op_e;

	typedef enum logic [2:0] {
		S_IDLE,
		S_REQ_READ,
		S_RSP_READ,
		S_REQ_WRITE,
		S_REQ_AW,    // w taken, aw still pending
		S_REQ_W,     // aw taken, w still pending
		S_RSP_WRITE,
		S_WB
	} lsu_state_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} bus_resp_e;

	// next requester after last, wrapping; last itself ranks lowest
	function automatic logic [LANE_W-1:0] rr_pick(input logic [NUM_LANES-1:0] req,
		input logic [LANE_W-1:0] last);
		logic [LANE_W-1:0] idx;
		rr_pick = last;
		for (int k = NUM_LANES; k >= 1; k--) begin
			idx = last + LANE_W'(k);
			if (req[idx])
				rr_pick = idx;
		end
	endfunction

endpackage

`default_nettype wire

//--- lsu_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface lsu_bus_if import lsu_pkg::*; ();

	logic [ADDR_W-1:0] araddr;
	logic              arvalid;
	logic              arready;
	logic [2:0]        arsize;

	logic [DATA_W-1:0] rdata;
	bus_resp_e         rresp;
	logic              rvalid;
	logic              rready;

	logic [ADDR_W-1:0] awaddr;
	logic              awvalid;
	logic              awready;

	logic [DATA_W-1:0] wdata;
	logic [STRB_W-1:0] wstrb;
	logic              wvalid;
	logic              wready;

	bus_resp_e         bresp;
	logic              bvalid;
	logic              bready;

	modport master (
		output araddr, arvalid, arsize, input arready,
		input rdata, rresp, rvalid, output rready,
		output awaddr, awvalid, input awready,
		output wdata, wstrb, wvalid, input wready,
		input bresp, bvalid, output bready
	);

	modport slave (
		input araddr, arvalid, arsize, output arready,
		output rdata, rresp, rvalid, input rready,
		input awaddr, awvalid, output awready,
		input wdata, wstrb, wvalid, output wready,
		output bresp, bvalid, input bready
	);

endinterface

`default_nettype wire

//--- lsu_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_dispatch import lsu_pkg::*; (
	input  logic                 req_valid,
	output logic                 req_ready,
	input  logic [NUM_LANES-1:0] lane_idle,
	output logic [NUM_LANES-1:0] lane_start
);

	logic [NUM_LANES-1:0] first_idle;

	always_comb begin
		first_idle = '0;
		for (int i = NUM_LANES - 1; i >= 0; i--) begin
			if (lane_idle[i])
				first_idle = NUM_LANES'(1) << i; // lowest index wins
		end
	end

	assign req_ready  = |lane_idle;
	assign lane_start = req_valid ? first_idle : '0;

endmodule

`default_nettype wire

//--- lsu_lane.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_lane import lsu_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	output logic              idle,
	input  lsu_op_e           op,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] wdata_in,
	input  logic [TAG_W-1:0]  tag,
	lsu_bus_if.master         bus,
	output logic              wb_valid,
	input  logic              wb_ready,
	output logic [TAG_W-1:0]  wb_tag,
	output logic [DATA_W-1:0] wb_data,
	output logic              wb_fault
);

	lsu_state_e        state;
	lsu_state_e        next_state;
	lsu_op_e           op_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [TAG_W-1:0]  tag_q;
	logic [DATA_W-1:0] result_q;
	logic              fault_q;
	logic [DATA_W-1:0] load_val;
	logic [7:0]        rd_byte;
	logic [15:0]       rd_half;
	logic [1:0]        offset;
	logic              is_load;
	logic              is_store;

	assign is_load  = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
	assign is_store = op inside {OP_SB, OP_SH, OP_SW};
	assign offset   = addr_q[1:0];

	assign idle        = (state == S_IDLE);
	assign bus.araddr  = addr_q;
	assign bus.awaddr  = addr_q;
	assign bus.arvalid = (state == S_REQ_READ);
	assign bus.rready  = (state == S_RSP_READ);
	assign bus.awvalid = (state == S_REQ_WRITE) || (state == S_REQ_AW);
	assign bus.wvalid  = (state == S_REQ_WRITE) || (state == S_REQ_W);
	assign bus.bready  = (state == S_RSP_WRITE);

	assign wb_valid = (state == S_WB);
	assign wb_tag   = tag_q;
	assign wb_data  = result_q;
	assign wb_fault = fault_q;

	always_comb begin
		case (op_q)
			OP_LH, OP_LHU: bus.arsize = 3'b001;
			OP_LW:         bus.arsize = 3'b010;
			default:       bus.arsize = 3'b000;
		endcase
	end

	// strobe and place store data by address
	always_comb begin
		case (op_q)
			OP_SB: begin
				bus.wstrb = STRB_W'(1) << offset;
				bus.wdata = DATA_W'(wdata_q[7:0]) << {offset, 3'b000};
			end
			OP_SH: begin
				bus.wstrb = STRB_W'(2'b11) << {offset[1], 1'b0}; // bit 0 ignored
				bus.wdata = DATA_W'(wdata_q[15:0]) << {offset[1], 4'b0000};
			end
			OP_SW: begin
				bus.wstrb = '1;
				bus.wdata = wdata_q;
			end
			default: begin
				bus.wstrb = '0;
				bus.wdata = '0;
			end
		endcase
	end

	assign rd_byte = bus.rdata[{offset, 3'b000} +: 8];
	assign rd_half = bus.rdata[{offset[1], 4'b0000} +: 16];

	always_comb begin
		case (op_q)
			OP_LB:   load_val = {{(DATA_W - 8){rd_byte[7]}}, rd_byte};
			OP_LBU:  load_val = {{(DATA_W - 8){1'b0}}, rd_byte};
			OP_LH:   load_val = {{(DATA_W - 16){rd_half[15]}}, rd_half};
			OP_LHU:  load_val = {{(DATA_W - 16){1'b0}}, rd_half};
			default: load_val = bus.rdata;
		endcase
	end

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE: begin
				if (start) begin
					if (is_load)
						next_state = S_REQ_READ;
					else if (is_store)
						next_state = S_REQ_WRITE;
					else
						next_state = S_WB; // pass-through
				end
			end
			S_REQ_READ:  if (bus.arready) next_state = S_RSP_READ;
			S_RSP_READ:  if (bus.rvalid) next_state = S_WB;
			S_REQ_WRITE: begin
				if (bus.awready && bus.wready)
					next_state = S_RSP_WRITE;
				else if (bus.awready)
					next_state = S_REQ_W;
				else if (bus.wready)
					next_state = S_REQ_AW;
			end
			S_REQ_AW:    if (bus.awready) next_state = S_RSP_WRITE;
			S_REQ_W:     if (bus.wready) next_state = S_RSP_WRITE;
			S_RSP_WRITE: if (bus.bvalid) next_state = S_WB;
			S_WB:        if (wb_ready) next_state = S_IDLE;
			default:     next_state = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= S_IDLE;
		else
			state <= next_state;
	end

	always_ff @(posedge clk) begin
		if (start && idle) begin
			op_q     <= op;
			addr_q   <= addr;
			wdata_q  <= wdata_in;
			tag_q    <= tag;
			result_q <= addr; // stores and pass keep the address
			fault_q  <= 1'b0;
		end else if (bus.rvalid && bus.rready) begin
			result_q <= load_val;
			fault_q  <= (bus.rresp != RESP_OKAY);
		end else if (bus.bvalid && bus.bready) begin
			fault_q  <= (bus.bresp != RESP_OKAY);
		end
	end

endmodule

`default_nettype wire

//--- lsu_bus_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_bus_arbiter import lsu_pkg::*; (
	input logic       clk,
	input logic       rst,
	lsu_bus_if.slave  lanes [NUM_LANES],
	lsu_bus_if.master mem
);

	logic [NUM_LANES-1:0] arvalid_a;
	logic [NUM_LANES-1:0] awvalid_a;
	logic [NUM_LANES-1:0] wvalid_a;
	logic [NUM_LANES-1:0] rready_a;
	logic [NUM_LANES-1:0] bready_a;
	logic [NUM_LANES-1:0] req;
	logic [ADDR_W-1:0]    araddr_a [NUM_LANES];
	logic [ADDR_W-1:0]    awaddr_a [NUM_LANES];
	logic [2:0]           arsize_a [NUM_LANES];
	logic [DATA_W-1:0]    wdata_a [NUM_LANES];
	logic [STRB_W-1:0]    wstrb_a [NUM_LANES];
	logic                 busy;
	logic [LANE_W-1:0]    grant;
	logic [LANE_W-1:0]    last;
	logic [LANE_W-1:0]    pick;
	logic [LANE_W-1:0]    cur;
	logic                 done;

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		assign araddr_a[i]  = lanes[i].araddr;
		assign arvalid_a[i] = lanes[i].arvalid;
		assign arsize_a[i]  = lanes[i].arsize;
		assign rready_a[i]  = lanes[i].rready;
		assign awaddr_a[i]  = lanes[i].awaddr;
		assign awvalid_a[i] = lanes[i].awvalid;
		assign wdata_a[i]   = lanes[i].wdata;
		assign wstrb_a[i]   = lanes[i].wstrb;
		assign wvalid_a[i]  = lanes[i].wvalid;
		assign bready_a[i]  = lanes[i].bready;

		// handshakes reach the current lane only
		assign lanes[i].arready = (cur == LANE_W'(i)) && mem.arready;
		assign lanes[i].rvalid  = (cur == LANE_W'(i)) && mem.rvalid;
		assign lanes[i].awready = (cur == LANE_W'(i)) && mem.awready;
		assign lanes[i].wready  = (cur == LANE_W'(i)) && mem.wready;
		assign lanes[i].bvalid  = (cur == LANE_W'(i)) && mem.bvalid;
		assign lanes[i].rdata   = mem.rdata;
		assign lanes[i].rresp   = mem.rresp;
		assign lanes[i].bresp   = mem.bresp;
	end

	assign req  = arvalid_a | awvalid_a | wvalid_a;
	assign pick = rr_pick(req, last);
	assign cur  = busy ? grant : pick; // no cycle lost on the first valid

	assign mem.araddr  = araddr_a[cur];
	assign mem.arvalid = arvalid_a[cur];
	assign mem.arsize  = arsize_a[cur];
	assign mem.rready  = rready_a[cur];
	assign mem.awaddr  = awaddr_a[cur];
	assign mem.awvalid = awvalid_a[cur];
	assign mem.wdata   = wdata_a[cur];
	assign mem.wstrb   = wstrb_a[cur];
	assign mem.wvalid  = wvalid_a[cur];
	assign mem.bready  = bready_a[cur];

	assign done = (mem.rvalid && mem.rready) || (mem.bvalid && mem.bready);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy  <= 1'b0;
			grant <= '0;
			last  <= LANE_W'(NUM_LANES - 1); // lane 0 goes first
		end else if (busy) begin
			if (done) begin
				busy <= 1'b0;
				last <= grant;
			end
		end else if (|req) begin
			busy  <= 1'b1;
			grant <= pick;
		end
	end

endmodule

`default_nettype wire

//--- lsu_data_ram.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_data_ram import lsu_pkg::*; #(
	parameter int RAM_WORDS = 256
) (
	input logic      clk,
	input logic      rst,
	lsu_bus_if.slave bus
);

	logic [DATA_W-1:0]            mem [RAM_WORDS];
	logic [$clog2(RAM_WORDS)-1:0] rd_idx;
	logic [$clog2(RAM_WORDS)-1:0] wr_idx;
	logic                         rd_ok;
	logic                         wr_ok;
	logic                         ar_rdy;
	logic                         wr_rdy;
	logic                         rd_hs;
	logic                         wr_hs;

	assign rd_idx = bus.araddr[$clog2(RAM_WORDS)+1:2];
	assign wr_idx = bus.awaddr[$clog2(RAM_WORDS)+1:2];
	assign rd_ok  = {2'b00, bus.araddr[ADDR_W-1:2]} < ADDR_W'(RAM_WORDS);
	assign wr_ok  = {2'b00, bus.awaddr[ADDR_W-1:2]} < ADDR_W'(RAM_WORDS);

	assign bus.arready = ar_rdy;
	assign bus.awready = wr_rdy; // aw and w accepted together
	assign bus.wready  = wr_rdy;
	assign rd_hs = bus.arvalid && ar_rdy;
	assign wr_hs = bus.awvalid && bus.wvalid && wr_rdy;

	always_ff @(posedge clk) begin
		if (rst) begin
			ar_rdy     <= 1'b0;
			wr_rdy     <= 1'b0;
			bus.rvalid <= 1'b0;
			bus.bvalid <= 1'b0;
		end else begin
			ar_rdy <= bus.arvalid && !ar_rdy && !bus.rvalid;
			wr_rdy <= bus.awvalid && bus.wvalid && !wr_rdy && !bus.bvalid;
			if (rd_hs)
				bus.rvalid <= 1'b1;
			else if (bus.rready)
				bus.rvalid <= 1'b0;
			if (wr_hs)
				bus.bvalid <= 1'b1;
			else if (bus.bready)
				bus.bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_hs) begin
			bus.rdata <= rd_ok ? mem[rd_idx] : '0;
			bus.rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
		if (wr_hs) begin
			bus.bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
			for (int b = 0; b < STRB_W; b++) begin
				if (wr_ok && bus.wstrb[b])
					mem[wr_idx][8*b +: 8] <= bus.wdata[8*b +: 8]; // out of range dropped
			end
		end
	end

endmodule

`default_nettype wire

//--- lsu_retire.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_retire import lsu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [NUM_LANES-1:0] lane_valid,
	input  logic [TAG_W-1:0]     lane_tag [NUM_LANES],
	input  logic [DATA_W-1:0]    lane_data [NUM_LANES],
	input  logic [NUM_LANES-1:0] lane_fault,
	output logic [NUM_LANES-1:0] lane_ready,
	output logic                 wb_valid,
	input  logic                 wb_ready,
	output logic [TAG_W-1:0]     wb_tag,
	output logic [DATA_W-1:0]    wb_data,
	output logic                 wb_fault
);

	logic [LANE_W-1:0] last;
	logic [LANE_W-1:0] sel;

	assign sel      = rr_pick(lane_valid, last);
	assign wb_valid = |lane_valid;
	assign wb_tag   = lane_tag[sel];
	assign wb_data  = lane_data[sel];
	assign wb_fault = lane_fault[sel];

	assign lane_ready = (wb_valid && wb_ready) ? (NUM_LANES'(1) << sel) : '0;

	always_ff @(posedge clk) begin
		if (rst)
			last <= LANE_W'(NUM_LANES - 1);
		else if (wb_valid && wb_ready)
			last <= sel; // winner drops to lowest rank
	end

endmodule

`default_nettype wire

//--- lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              req_valid,
	output logic              req_ready,
	input  lsu_op_e           req_op,
	input  logic [ADDR_W-1:0] req_addr,
	input  logic [DATA_W-1:0] req_wdata,
	input  logic [TAG_W-1:0]  req_tag,
	output logic              wb_valid,
	input  logic              wb_ready,
	output logic [TAG_W-1:0]  wb_tag,
	output logic [DATA_W-1:0] wb_data,
	output logic              wb_fault
);

	logic [NUM_LANES-1:0] lane_idle;
	logic [NUM_LANES-1:0] lane_start;
	logic [NUM_LANES-1:0] lane_wb_valid;
	logic [NUM_LANES-1:0] lane_wb_ready;
	logic [NUM_LANES-1:0] lane_wb_fault;
	logic [TAG_W-1:0]     lane_wb_tag [NUM_LANES];
	logic [DATA_W-1:0]    lane_wb_data [NUM_LANES];

	lsu_bus_if lane_bus [NUM_LANES] ();
	lsu_bus_if mem_bus ();

	lsu_dispatch u_dispatch (
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.lane_idle  (lane_idle),
		.lane_start (lane_start)
	);

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		lsu_lane u_lane (
			.clk      (clk),
			.rst      (rst),
			.start    (lane_start[i]),
			.idle     (lane_idle[i]),
			.op       (req_op),
			.addr     (req_addr),
			.wdata_in (req_wdata),
			.tag      (req_tag),
			.bus      (lane_bus[i]),
			.wb_valid (lane_wb_valid[i]),
			.wb_ready (lane_wb_ready[i]),
			.wb_tag   (lane_wb_tag[i]),
			.wb_data  (lane_wb_data[i]),
			.wb_fault (lane_wb_fault[i])
		);
	end

	lsu_bus_arbiter u_bus_arbiter (
		.clk   (clk),
		.rst   (rst),
		.lanes (lane_bus),
		.mem   (mem_bus)
	);

	lsu_data_ram u_data_ram (
		.clk (clk),
		.rst (rst),
		.bus (mem_bus)
	);

	lsu_retire u_retire (
		.clk        (clk),
		.rst        (rst),
		.lane_valid (lane_wb_valid),
		.lane_tag   (lane_wb_tag),
		.lane_data  (lane_wb_data),
		.lane_fault (lane_wb_fault),
		.lane_ready (lane_wb_ready),
		.wb_valid   (wb_valid),
		.wb_ready   (wb_ready),
		.wb_tag     (wb_tag),
		.wb_data    (wb_data),
		.wb_fault   (wb_fault)
	);

endmodule

`default_nettype wire

//--- lsu_properties.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_properties import lsu_pkg::*; (
	input logic              clk,
	input logic              rst,
	input logic              busy,
	input logic              done,
	input logic              arvalid,
	input logic              arready,
	input logic [ADDR_W-1:0] araddr,
	input logic              awvalid,
	input logic              awready,
	input logic [ADDR_W-1:0] awaddr,
	input logic              wvalid,
	input logic              wready,
	input logic [DATA_W-1:0] wdata,
	input logic [STRB_W-1:0] wstrb,
	input logic              rvalid,
	input logic              bvalid
);

	logic ar_hs;
	logic aw_hs;
	logic open_q; // address taken, response not yet

	assign ar_hs = arvalid && arready;
	assign aw_hs = awvalid && awready;

	always_ff @(posedge clk) begin
		if (rst)
			open_q <= 1'b0;
		else if (done)
			open_q <= 1'b0;
		else if (ar_hs || aw_hs)
			open_q <= 1'b1;
	end

	ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("arvalid dropped or araddr moved before arready");

	aw_hold: assert property (@(posedge clk) disable iff (rst)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else $error("awvalid dropped or awaddr moved before awready");

	w_hold: assert property (@(posedge clk) disable iff (rst)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
		else $error("wvalid dropped or write data moved before wready");

	// one owner until its response
	one_owner: assert property (@(posedge clk) disable iff (rst)
		open_q |-> busy && !ar_hs && !aw_hs)
		else $error("second address accepted while a transaction is open");

	rsp_owned: assert property (@(posedge clk) disable iff (rst)
		rvalid || bvalid |-> open_q)
		else $error("response seen with no outstanding request");

endmodule

bind lsu_bus_arbiter lsu_properties u_props (
	.clk     (clk),
	.rst     (rst),
	.busy    (busy),
	.done    (done),
	.arvalid (mem.arvalid),
	.arready (mem.arready),
	.araddr  (mem.araddr),
	.awvalid (mem.awvalid),
	.awready (mem.awready),
	.awaddr  (mem.awaddr),
	.wvalid  (mem.wvalid),
	.wready  (mem.wready),
	.wdata   (mem.wdata),
	.wstrb   (mem.wstrb),
	.rvalid  (mem.rvalid),
	.bvalid  (mem.bvalid)
);

`default_nettype wire

//--- lsu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

	logic              clk;
	logic              rst;
	logic              req_valid;
	logic              req_ready;
	lsu_op_e           req_op;
	logic [ADDR_W-1:0] req_addr;
	logic [DATA_W-1:0] req_wdata;
	logic [TAG_W-1:0]  req_tag;
	logic              wb_valid;
	logic              wb_ready;
	logic [TAG_W-1:0]  wb_tag;
	logic [DATA_W-1:0] wb_data;
	logic              wb_fault;

	byte               g_phase [64];
	logic [3:0]        g_op [64];
	logic [ADDR_W-1:0] g_addr [64];
	logic [DATA_W-1:0] g_wdata [64];
	logic [TAG_W-1:0]  g_tag [64];
	logic [DATA_W-1:0] g_exp [64];
	logic              g_fault [64];
	int                n_ops;

	int                got_cnt [2**TAG_W];
	logic [DATA_W-1:0] got_data [2**TAG_W];
	logic              got_fault [2**TAG_W];

	int                n_acc;
	int                n_ret;
	logic              accepted;
	logic              rnd_on;
	logic [31:0]       lfsr;
	int                checks;
	int                errors;
	int                timeouts;
	int                wait_limit = 500; // cycles per wait

	lsu_top dut_i (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_op    (req_op),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_tag   (req_tag),
		.wb_valid  (wb_valid),
		.wb_ready  (wb_ready),
		.wb_tag    (wb_tag),
		.wb_data   (wb_data),
		.wb_fault  (wb_fault)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1, right shifting
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at time %0t: %s got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// handshakes committed by this edge
	task automatic observe();
		int busy_lanes;
		if (!rst) begin
			busy_lanes = n_acc - n_ret;
			compare("req_ready", 32'(req_ready), 32'(busy_lanes < NUM_LANES));
			if (req_valid && req_ready) begin
				accepted = 1'b1;
				n_acc++;
			end
			if (wb_valid && wb_ready) begin
				got_cnt[wb_tag]++;
				got_data[wb_tag]  = wb_data;
				got_fault[wb_tag] = wb_fault;
				n_ret++;
			end
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		observe();
		@(negedge clk);
		if (rnd_on) begin
			lfsr     = lfsr_next(lfsr);
			wb_ready = lfsr[0];
		end else begin
			wb_ready = 1'b1;
		end
	endtask

	task automatic load_golden();
		int          fd;
		int          cnt;
		string       text;
		byte         ph;
		logic [31:0] f_op;
		logic [31:0] f_addr;
		logic [31:0] f_wdata;
		logic [31:0] f_tag;
		logic [31:0] f_exp;
		logic [31:0] f_fault;
		n_ops = 0;
		fd = $fopen("lsu_golden.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open lsu_golden.txt");
			return;
		end
		while (!$feof(fd) && n_ops < 64) begin
			text = "";
			void'($fgets(text, fd));
			if (text.len() > 1 && text[0] != "#") begin
				cnt = $sscanf(text, "%c %h %h %h %h %h %h", ph, f_op, f_addr, f_wdata,
					f_tag, f_exp, f_fault);
				if (cnt == 7) begin
					g_phase[n_ops] = ph;
					g_op[n_ops]    = f_op[3:0];
					g_addr[n_ops]  = f_addr;
					g_wdata[n_ops] = f_wdata;
					g_tag[n_ops]   = f_tag[TAG_W-1:0];
					g_exp[n_ops]   = f_exp;
					g_fault[n_ops] = f_fault[0];
					n_ops++;
				end else begin
					errors++;
					$display("unreadable line in lsu_golden.txt: %s", text);
				end
			end
		end
		$fclose(fd);
		if (n_ops == 0) begin
			errors++;
			$display("lsu_golden.txt holds no operations");
		end
	endtask

	task automatic issue(input int k);
		int guard;
		req_valid = 1'b1;
		req_op    = lsu_op_e'(g_op[k]);
		req_addr  = g_addr[k];
		req_wdata = g_wdata[k];
		req_tag   = g_tag[k];
		accepted  = 1'b0;
		guard     = 0;
		while (!accepted && guard < wait_limit) begin
			next_cycle();
			guard++;
		end
		if (!accepted) begin
			timeouts++;
			$display("timeout: request with tag %0d was never accepted", g_tag[k]);
		end
	endtask

	task automatic wait_result(input logic [TAG_W-1:0] t);
		int guard;
		guard = 0;
		while (got_cnt[t] == 0 && guard < wait_limit) begin
			next_cycle();
			guard++;
		end
		if (got_cnt[t] == 0) begin
			timeouts++;
			$display("timeout: no result came back for tag %0d", t);
		end
	endtask

	task automatic wait_drain();
		int guard;
		guard = 0;
		while (n_ret < n_acc && guard < wait_limit) begin
			next_cycle();
			guard++;
		end
		if (n_ret < n_acc) begin
			timeouts++;
			$display("timeout: %0d results still outstanding", n_acc - n_ret);
		end
	endtask

	task automatic check_result(input int k);
		logic [TAG_W-1:0] t;
		t = g_tag[k];
		compare($sformatf("tag %0d retire count", t), 32'(got_cnt[t]), 32'd1);
		compare($sformatf("tag %0d data", t), got_data[t], g_exp[k]);
		compare($sformatf("tag %0d fault", t), 32'(got_fault[t]), 32'(g_fault[k]));
	endtask

	initial begin
		rst       = 1'b1;
		req_valid = 1'b0;
		req_op    = OP_PASS;
		req_addr  = '0;
		req_wdata = '0;
		req_tag   = '0;
		wb_ready  = 1'b1;
		rnd_on    = 1'b0;
		lfsr      = 32'hcb40;
		accepted  = 1'b0;
		n_acc     = 0;
		n_ret     = 0;
		checks    = 0;
		errors    = 0;
		timeouts  = 0;
		for (int t = 0; t < 2**TAG_W; t++)
			got_cnt[t] = 0;
		load_golden();
		repeat (2) next_cycle();
		rst = 1'b0;
		compare("wb_valid after reset", 32'(wb_valid), 32'd0);
		compare("req_ready after reset", 32'(req_ready), 32'd1);

		// one request in flight
		for (int k = 0; k < n_ops; k++) begin
			if (g_phase[k] == "S") begin
				issue(k);
				req_valid = 1'b0;
				wait_result(g_tag[k]);
				check_result(k);
			end
		end

		// burst, results out of order under back-pressure
		for (int t = 0; t < 2**TAG_W; t++)
			got_cnt[t] = 0;
		rnd_on = 1'b1;
		for (int k = 0; k < n_ops; k++) begin
			if (g_phase[k] == "L")
				issue(k);
		end
		req_valid = 1'b0;
		wait_drain();
		rnd_on = 1'b0;
		for (int k = 0; k < n_ops; k++) begin
			if (g_phase[k] == "L")
				check_result(k);
		end
		compare("total retired", 32'(n_ret), 32'(n_acc));

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- lsu_golden.txt
# phase op addr wdata tag exp_data exp_fault, all hex; S one at a time, L back to back
# op: 0 pass, 1 lb, 2 lh, 3 lw, 4 lbu, 5 lhu, 6 sb, 7 sh, 8 sw
S 8 00000010 11223344 01 00000010 0
S 3 00000010 00000000 02 11223344 0
S 6 00000011 000000ab 03 00000011 0
S 7 00000012 0000cdef 04 00000012 0
S 3 00000010 00000000 05 cdefab44 0
S 8 00000030 ffffffff 06 00000030 0
S 6 00000033 00000012 07 00000033 0
S 7 00000030 00003456 08 00000030 0
S 3 00000030 00000000 09 12ff3456 0
S 8 00000020 80ff7f01 0a 00000020 0
S 1 00000020 00000000 0b 00000001 0
S 1 00000021 00000000 0c 0000007f 0
S 1 00000022 00000000 0d ffffffff 0
S 1 00000023 00000000 0e ffffff80 0
S 4 00000022 00000000 0f 000000ff 0
S 4 00000023 00000000 10 00000080 0
S 2 00000020 00000000 11 00007f01 0
S 2 00000022 00000000 12 ffff80ff 0
S 5 00000022 00000000 13 000080ff 0
S 2 00000021 00000000 14 00007f01 0
S 0 deadbeef 00000000 15 deadbeef 0
S 8 00000410 55555555 16 00000410 1
S 3 00000410 00000000 17 00000000 1
S 1 00001003 00000000 18 00000000 1
S 3 00000010 00000000 19 cdefab44 0
L 3 00000010 00000000 01 cdefab44 0
L 3 00000020 00000000 02 80ff7f01 0
L 4 00000020 00000000 03 00000001 0
L 4 00000021 00000000 04 0000007f 0
L 2 00000032 00000000 05 000012ff 0
L 0 00001234 00000000 06 00001234 0
L 3 00000800 00000000 07 00000000 1
L 5 00000012 00000000 08 0000cdef 0
L 3 00000030 00000000 09 12ff3456 0

//--- compile.f
lsu_pkg.sv
lsu_bus_if.sv
lsu_dispatch.sv
lsu_lane.sv
lsu_bus_arbiter.sv
lsu_data_ram.sv
lsu_retire.sv
lsu_top.sv
lsu_properties.sv
lsu_tb.sv

//--- Makefile
SRC := $(shell cat compile.f)

obj_dir/Vlsu_tb: compile.f $(SRC)
	verilator --binary --timing --assert --top-module lsu_tb -f compile.f -o Vlsu_tb

run: obj_dir/Vlsu_tb
	./obj_dir/Vlsu_tb | tee sim.log
	! grep -q "RESULT: FAIL" sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
